//--- src/fdc_macros.svh
/* opcodes, main status and st3 bit positions,
   fixed status byte values and result queue depth */

`ifndef FDC_MACROS_SVH
`define FDC_MACROS_SVH

// ============================================================================
// command bytes
// ============================================================================
`define FDC_OP_SPECIFY     8'h03
`define FDC_OP_SENSE_DRIVE 8'h04
`define FDC_OP_RECAL       8'h07
`define FDC_OP_SENSE_INT   8'h08
`define FDC_OP_SEEK        8'h0F

// main status register bits
`define FDC_MSR_CB  4
`define FDC_MSR_DIO 6
`define FDC_MSR_RQM 7

// st3 bits
`define FDC_ST3_US0 0
`define FDC_ST3_T0  4
`define FDC_ST3_RDY 5
`define FDC_ST3_WP  6

// st0 values
`define FDC_ST0_SEEK_END 8'h20
`define FDC_ST0_SEEK_ERR 8'hE8
`define FDC_ST0_INVALID  8'h80

`define FDC_DATA_IDLE    8'hFF // data read with nothing queued
`define FDC_RESULT_DEPTH 4

`endif

//--- src/fdc_pkg.sv
/* fdc_pkg package
   byte and cylinder vector types, result queue count, sequencer FSM states */

package fdc_pkg;

	// ========================================================================
	// vector types
	// ========================================================================

	typedef logic [7:0] byte_t;         // host bus and result bytes
	typedef logic [7:0] cyl_t;          // present or new cylinder
	typedef logic [2:0] result_count_t; // queue fill, 0 to 4

	// ========================================================================
	// command sequencer states
	// ========================================================================

	typedef enum logic [3:0] {
		idle,           // waiting for an opcode
		specify_p1,     // step rate / head unload byte
		specify_p2,     // head load / dma byte
		sense_drive_p1, // unit select byte
		recal_p1,       // unit select byte
		seek_p1,        // unit select byte
		seek_p2,        // new cylinder byte
		sense_int,      // st0 and pcn out
		invalid,        // single 80h result
		push_results    // st3 out
	} seq_state_t;

endpackage

//--- src/fdc_host_port.sv
/* fdc_host_port module
   strobe synchronisers, edge detect and a0 register select */

`timescale 1ns/1ps

module fdc_host_port (
	input  logic           clk_sys,
	input  logic           rst_n,
	input  logic           a0,
	input  logic           nrd,
	input  logic           nwr,
	input  fdc_pkg::byte_t din,
	output logic           data_wr,
	output logic           data_rd,
	output logic           status_rd,
	output fdc_pkg::byte_t wr_byte
);

	logic       rd_req;
	logic       wr_req;
	logic [1:0] rd_sync;
	logic [1:0] wr_sync;
	logic       rd_old;
	logic       wr_old;
	logic       rd_pulse;
	logic       wr_pulse;

	// strobes are active low on the bus
	assign rd_req = ~nrd;
	assign wr_req = ~nwr;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rd_sync <= '0;
			wr_sync <= '0;
			rd_old  <= 1'b0;
			wr_old  <= 1'b0;
		end else begin
			rd_sync <= {rd_sync[0], rd_req};
			wr_sync <= {wr_sync[0], wr_req};
			rd_old  <= rd_sync[1]; // edge detect stage
			wr_old  <= wr_sync[1];
		end
	end

	// sampled at the edge where wr_sync[1] rises
	always_ff @(posedge clk_sys) begin
		wr_byte <= din;
	end

	assign rd_pulse  = rd_sync[1] & ~rd_old;
	assign wr_pulse  = wr_sync[1] & ~wr_old;
	assign data_rd   = rd_pulse & a0;
	assign status_rd = rd_pulse & ~a0;
	assign data_wr   = wr_pulse & a0; // writes with a0 low go nowhere

	a_rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(rd_pulse && wr_pulse))
		else $error("read and write pulse in the same cycle");

endmodule

//--- src/fdc_command_sequencer.sv
/* fdc_command_sequencer module
   opcode decode, parameter bytes, immediate seek and result pushes */

`timescale 1ns/1ps
`include "fdc_macros.svh"

module fdc_command_sequencer (
	input  logic           clk_sys,
	input  logic           rst_n,
	input  logic           data_wr,
	input  fdc_pkg::byte_t wr_byte,
	input  logic           results_pending,
	input  logic           media_present,
	input  fdc_pkg::cyl_t  media_tracks,
	output logic           push,
	output fdc_pkg::byte_t push_byte,
	output logic           busy
);

	fdc_pkg::seq_state_t state;
	fdc_pkg::cyl_t       pcn;         // present cylinder
	fdc_pkg::byte_t      st0;         // held for sense interrupt
	fdc_pkg::byte_t      st3;
	logic                int_pending;
	logic                unit_sel;
	logic                push_idx;    // 0 st0, 1 pcn
	logic                wr_ok;
	logic                seek_ok;

	// no new bytes until the host has drained the results
	assign wr_ok = data_wr & ~results_pending;

	// cylinder 0 always reachable, others need media and range
	assign seek_ok = (wr_byte == '0) || (media_present && (wr_byte < media_tracks));

	always_comb begin
		st3                = '0;
		st3[`FDC_ST3_US0]  = unit_sel;
		st3[`FDC_ST3_T0]   = (pcn == '0);
		st3[`FDC_ST3_RDY]  = media_present;
		st3[`FDC_ST3_WP]   = ~media_present; // no media reads as protected
	end

	assign busy = (state != fdc_pkg::idle);

	// ========================================================================
	// result pushes, one byte per cycle straight from the state
	// ========================================================================

	always_comb begin
		push      = 1'b0;
		push_byte = st0;
		case (state)
			fdc_pkg::sense_int: begin
				push = 1'b1;
				if (push_idx)
					push_byte = pcn;
				else if (!int_pending)
					push_byte = `FDC_ST0_INVALID; // nothing to report
			end
			fdc_pkg::invalid: begin
				push      = 1'b1;
				push_byte = `FDC_ST0_INVALID;
			end
			fdc_pkg::push_results: begin
				push      = 1'b1;
				push_byte = unit_sel ? 8'h01 : st3; // unit 1 not fitted
			end
			default: ;
		endcase
	end

	// ========================================================================
	// command FSM
	// ========================================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state       <= fdc_pkg::idle;
			pcn         <= '0;
			st0         <= '0;
			int_pending <= 1'b0;
			unit_sel    <= 1'b0;
			push_idx    <= 1'b0;
		end else begin
			case (state)
				fdc_pkg::idle: if (wr_ok) begin
					push_idx <= 1'b0;
					case (wr_byte)
						`FDC_OP_SPECIFY:     state <= fdc_pkg::specify_p1;
						`FDC_OP_SENSE_DRIVE: state <= fdc_pkg::sense_drive_p1;
						`FDC_OP_RECAL:       state <= fdc_pkg::recal_p1;
						`FDC_OP_SEEK:        state <= fdc_pkg::seek_p1;
						`FDC_OP_SENSE_INT:   state <= fdc_pkg::sense_int;
						default:             state <= fdc_pkg::invalid;
					endcase
				end
				fdc_pkg::specify_p1: if (wr_ok) state <= fdc_pkg::specify_p2;
				fdc_pkg::specify_p2: if (wr_ok) state <= fdc_pkg::idle; // timings unused
				fdc_pkg::sense_drive_p1: if (wr_ok) begin
					unit_sel <= wr_byte[0];
					state    <= fdc_pkg::push_results;
				end
				fdc_pkg::recal_p1: if (wr_ok) begin
					pcn         <= '0;
					st0         <= `FDC_ST0_SEEK_END;
					int_pending <= 1'b1;
					state       <= fdc_pkg::idle;
				end
				fdc_pkg::seek_p1: if (wr_ok) state <= fdc_pkg::seek_p2;
				fdc_pkg::seek_p2: if (wr_ok) begin
					if (seek_ok) begin
						pcn <= wr_byte;
						st0 <= `FDC_ST0_SEEK_END;
					end else begin
						st0 <= `FDC_ST0_SEEK_ERR; // head stays put
					end
					int_pending <= 1'b1;
					state       <= fdc_pkg::idle;
				end
				fdc_pkg::sense_int: begin
					if (push_idx) begin
						push_idx <= 1'b0;
						state    <= fdc_pkg::idle;
					end else if (int_pending) begin
						int_pending <= 1'b0;
						push_idx    <= 1'b1;
					end else begin
						state <= fdc_pkg::idle;
					end
				end
				fdc_pkg::invalid:      state <= fdc_pkg::idle;
				fdc_pkg::push_results: state <= fdc_pkg::idle;
				default:               state <= fdc_pkg::idle;
			endcase
		end
	end

	// a result burst only starts into an empty queue
	a_push_into_empty: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(push) |-> !results_pending)
		else $error("result burst started with results still queued");

endmodule

//--- src/fdc_result_port.sv
/* fdc_result_port module
   result FIFO, main status register and registered read data */

`timescale 1ns/1ps
`include "fdc_macros.svh"

module fdc_result_port (
	input  logic           clk_sys,
	input  logic           rst_n,
	input  logic           data_rd,
	input  logic           status_rd,
	input  logic           push,
	input  fdc_pkg::byte_t push_byte,
	input  logic           busy,
	output logic           results_pending,
	output fdc_pkg::byte_t dout
);

	localparam int DEPTH = `FDC_RESULT_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	fdc_pkg::byte_t         mem [DEPTH];
	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	fdc_pkg::result_count_t count;
	fdc_pkg::byte_t         msr;
	logic                   pop;

	assign results_pending = (count != '0);
	assign pop             = data_rd & results_pending;

	always_comb begin
		msr               = '0;
		msr[`FDC_MSR_RQM] = 1'b1;                    // always ready
		msr[`FDC_MSR_DIO] = results_pending;          // data toward host
		msr[`FDC_MSR_CB]  = busy | results_pending;
	end

	always_ff @(posedge clk_sys) begin
		if (push)
			mem[wr_ptr] <= push_byte;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			dout   <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
			if (status_rd)
				dout <= msr;
			else if (data_rd)
				dout <= pop ? mem[rd_ptr] : `FDC_DATA_IDLE;
		end
	end

	a_no_push_full: assert property (@(posedge clk_sys) disable iff (!rst_n)
		push |-> (count != fdc_pkg::result_count_t'(DEPTH)))
		else $error("push into a full result queue");

	a_count_range: assert property (@(posedge clk_sys) disable iff (!rst_n)
		count <= fdc_pkg::result_count_t'(DEPTH))
		else $error("result count above queue depth");

endmodule

//--- src/fdc_top.sv
/* fdc_top module
   host port, command sequencer and result port */

`timescale 1ns/1ps

module fdc_top (
	input  logic           clk_sys,
	input  logic           rst_n,
	input  logic           a0,
	input  logic           nrd,
	input  logic           nwr,
	input  fdc_pkg::byte_t din,
	input  logic           media_present,
	input  fdc_pkg::cyl_t  media_tracks,
	output fdc_pkg::byte_t dout
);

	logic           data_wr;
	logic           data_rd;
	logic           status_rd;
	fdc_pkg::byte_t wr_byte;
	logic           push;
	fdc_pkg::byte_t push_byte;
	logic           busy;
	logic           results_pending;

	// bus side
	fdc_host_port u_host_port (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.a0        (a0),
		.nrd       (nrd),
		.nwr       (nwr),
		.din       (din),
		.data_wr   (data_wr),
		.data_rd   (data_rd),
		.status_rd (status_rd),
		.wr_byte   (wr_byte)
	);

	fdc_command_sequencer u_sequencer (
		.clk_sys         (clk_sys),
		.rst_n           (rst_n),
		.data_wr         (data_wr),
		.wr_byte         (wr_byte),
		.results_pending (results_pending),
		.media_present   (media_present),
		.media_tracks    (media_tracks),
		.push            (push),
		.push_byte       (push_byte),
		.busy            (busy)
	);

	fdc_result_port u_result_port (
		.clk_sys         (clk_sys),
		.rst_n           (rst_n),
		.data_rd         (data_rd),
		.status_rd       (status_rd),
		.push            (push),
		.push_byte       (push_byte),
		.busy            (busy),
		.results_pending (results_pending),
		.dout            (dout)
	);

endmodule

//--- tb/tb_fdc_model.svh
/* reference model of the command rules and typed compare tasks,
   included inside the testbench module */

`ifndef TB_FDC_MODEL_SVH
`define TB_FDC_MODEL_SVH

fdc_pkg::cyl_t  m_pcn;         // model head position
fdc_pkg::byte_t m_st0;
logic           m_int_pending;
int             result_errors;
int             status_errors;

task automatic model_reset();
	m_pcn         = '0;
	m_st0         = '0;
	m_int_pending = 1'b0;
endtask

// expected result bytes for one command, returns how many there are
function automatic int predict_results(
	input  fdc_pkg::byte_t op,
	input  fdc_pkg::byte_t unit_byte,
	input  fdc_pkg::cyl_t  ncn,
	input  logic           present,
	input  fdc_pkg::cyl_t  tracks,
	output fdc_pkg::byte_t exp_a,
	output fdc_pkg::byte_t exp_b
);
	int n;
	n     = 0;
	exp_a = '0;
	exp_b = '0;
	case (op)
		`FDC_OP_SPECIFY: n = 0; // parameters swallowed
		`FDC_OP_SENSE_DRIVE: begin
			n = 1;
			if (unit_byte[0]) begin
				exp_a = 8'h01;
			end else begin
				exp_a[`FDC_ST3_T0]  = (m_pcn == 8'h00);
				exp_a[`FDC_ST3_RDY] = present;
				exp_a[`FDC_ST3_WP]  = !present;
			end
		end
		`FDC_OP_RECAL: begin
			m_pcn         = '0;
			m_st0         = `FDC_ST0_SEEK_END;
			m_int_pending = 1'b1;
		end
		`FDC_OP_SEEK: begin
			if (ncn == 8'h00 || (present && ncn < tracks)) begin
				m_pcn = ncn;
				m_st0 = `FDC_ST0_SEEK_END;
			end else begin
				m_st0 = `FDC_ST0_SEEK_ERR;
			end
			m_int_pending = 1'b1;
		end
		`FDC_OP_SENSE_INT: begin
			if (m_int_pending) begin
				n             = 2;
				exp_a         = m_st0;
				exp_b         = m_pcn;
				m_int_pending = 1'b0;
			end else begin
				n     = 1;
				exp_a = `FDC_ST0_INVALID; // nothing to report
			end
		end
		default: begin
			n     = 1;
			exp_a = `FDC_ST0_INVALID;
		end
	endcase
	return n;
endfunction

task automatic check_result(input fdc_pkg::byte_t got, input fdc_pkg::byte_t exp,
		input string what);
	if (got !== exp) begin
		result_errors++;
		$display("ERR %0t ns: %s read %02h, expected %02h", $time, what, got, exp);
	end
endtask

task automatic check_status(input fdc_pkg::byte_t got, input fdc_pkg::byte_t exp,
		input string what);
	if (got !== exp) begin
		status_errors++;
		$display("ERR %0t ns: %s read %02h, expected %02h", $time, what, got, exp);
	end
endtask

`endif

//--- tb/tb_fdc.sv
/* testbench for fdc_top: clock, reset, host bus tasks,
   command scenarios, watchdog and closing error report */

`timescale 1ns/1ps
`include "fdc_macros.svh"

module tb_fdc;

	localparam int STROBE_CYCLES = 6;
	localparam int IDLE_CYCLES   = 5;
	localparam int MAX_POLLS     = 50;
	localparam int N_SEEK        = 16;
	localparam int N_BAD         = 8;
	localparam int STEPS         = 1 + 2 * N_SEEK + 3 + 16 + 1 + N_BAD;
	localparam fdc_pkg::byte_t MSR_IDLE    = 8'h80;
	localparam fdc_pkg::byte_t MSR_PENDING = 8'hD0; // rqm, dio, cb

	logic           clk_sys;
	logic           rst_n;
	logic           a0;
	logic           nrd;
	logic           nwr;
	fdc_pkg::byte_t din;
	logic           media_present;
	fdc_pkg::cyl_t  media_tracks;
	fdc_pkg::byte_t dout;
	int             other_errors;

	`include "tb_fdc_model.svh"

	fdc_top UUT (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.a0            (a0),
		.nrd           (nrd),
		.nwr           (nwr),
		.din           (din),
		.media_present (media_present),
		.media_tracks  (media_tracks),
		.dout          (dout)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ========================================================================
	// host bus cycles
	// ========================================================================

	task automatic write_data(input fdc_pkg::byte_t value);
		@(posedge clk_sys);
		#1;
		a0  = 1'b1;
		din = value;
		nwr = 1'b0;
		repeat (STROBE_CYCLES) @(posedge clk_sys);
		#1;
		nwr = 1'b1;
		repeat (IDLE_CYCLES) @(posedge clk_sys);
	endtask

	// sel high for data, low for main status
	task automatic read_port(input logic sel, output fdc_pkg::byte_t value);
		@(posedge clk_sys);
		#1;
		a0  = sel;
		nrd = 1'b0;
		repeat (STROBE_CYCLES) @(posedge clk_sys);
		#1;
		value = dout; // loaded well before the strobe ends
		nrd   = 1'b1;
		repeat (IDLE_CYCLES) @(posedge clk_sys);
	endtask

	task automatic wait_results(output fdc_pkg::byte_t st, output logic ready);
		int polls;
		ready = 1'b0;
		st    = '0;
		for (polls = 0; polls < MAX_POLLS && !ready; polls++) begin
			read_port(1'b0, st);
			ready = st[`FDC_MSR_DIO];
		end
		if (!ready) begin
			other_errors++;
			$display("result data never became ready after %0d status polls", MAX_POLLS);
		end
	endtask

	// opcode, its parameters, then every result against the model
	task automatic run_command(input fdc_pkg::byte_t op, input fdc_pkg::byte_t unit_byte,
			input fdc_pkg::cyl_t ncn);
		fdc_pkg::byte_t exp_a;
		fdc_pkg::byte_t exp_b;
		fdc_pkg::byte_t got;
		logic           ready;
		int             n;
		n = predict_results(op, unit_byte, ncn, media_present, media_tracks, exp_a, exp_b);
		write_data(op);
		case (op)
			`FDC_OP_SPECIFY: begin
				write_data(fdc_pkg::byte_t'($urandom_range(0, 255)));
				write_data(fdc_pkg::byte_t'($urandom_range(0, 255)));
			end
			`FDC_OP_SENSE_DRIVE, `FDC_OP_RECAL: write_data(unit_byte);
			`FDC_OP_SEEK: begin
				write_data(unit_byte);
				write_data(ncn);
			end
			default: ;
		endcase
		if (n > 0) begin
			wait_results(got, ready);
			if (ready) begin
				check_status(got, MSR_PENDING, $sformatf("op %02h pending status", op));
				read_port(1'b1, got);
				check_result(got, exp_a, $sformatf("op %02h first result", op));
				if (n > 1) begin
					read_port(1'b1, got);
					check_result(got, exp_b, $sformatf("op %02h second result", op));
				end
			end
		end
		read_port(1'b0, got);
		check_status(got, MSR_IDLE, $sformatf("op %02h status after results", op));
	endtask

	// ========================================================================
	// scenarios
	// ========================================================================

	initial begin
		fdc_pkg::byte_t got;
		fdc_pkg::byte_t op;
		fdc_pkg::cyl_t  cyl_list [4];
		logic           present_list [4];
		int             i;
		rst_n         = 1'b0;
		a0            = 1'b0;
		nrd           = 1'b1;
		nwr           = 1'b1;
		din           = '0;
		media_present = 1'b0;
		media_tracks  = '0;
		other_errors  = 0;
		void'($urandom(32'h4cc2d52b));
		model_reset();
		repeat (5) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;

		check_result(dout, 8'h00, "dout after reset");
		read_port(1'b0, got);
		check_status(got, MSR_IDLE, "status after reset");
		read_port(1'b1, got);
		check_result(got, `FDC_DATA_IDLE, "data read of empty queue");

		for (i = 0; i < N_SEEK; i++) begin
			@(posedge clk_sys);
			#1;
			media_present = ~media_present;
			media_tracks  = fdc_pkg::cyl_t'($urandom_range(1, 200));
			run_command(`FDC_OP_SEEK, 8'h00,
				(i % 5 == 0) ? 8'h00 : fdc_pkg::cyl_t'($urandom_range(0, 220)));
			run_command(`FDC_OP_SENSE_INT, 8'h00, 8'h00);
		end

		// recal then two sense interrupts, the second one empty
		@(posedge clk_sys);
		#1;
		media_present = 1'b1;
		run_command(`FDC_OP_RECAL, 8'h00, 8'h00);
		run_command(`FDC_OP_SENSE_INT, 8'h00, 8'h00);
		run_command(`FDC_OP_SENSE_INT, 8'h00, 8'h00);

		present_list = '{1'b1, 1'b1, 1'b0, 1'b0};
		cyl_list     = '{8'd0, 8'd12, 8'd12, 8'd0}; // third seek fails, head stays at 12
		for (i = 0; i < 4; i++) begin
			@(posedge clk_sys);
			#1;
			media_present = present_list[i];
			media_tracks  = 8'd80;
			run_command(`FDC_OP_SEEK, 8'h00, cyl_list[i]);
			run_command(`FDC_OP_SENSE_INT, 8'h00, 8'h00);
			run_command(`FDC_OP_SENSE_DRIVE, 8'h00, 8'h00);
			run_command(`FDC_OP_SENSE_DRIVE, 8'h01, 8'h00);
		end

		run_command(`FDC_OP_SPECIFY, 8'h00, 8'h00);
		read_port(1'b1, got);
		check_result(got, `FDC_DATA_IDLE, "data read after specify");

		for (i = 0; i < N_BAD; i++) begin
			do begin
				op = fdc_pkg::byte_t'($urandom_range(0, 255));
			end while (op == `FDC_OP_SPECIFY || op == `FDC_OP_SENSE_DRIVE ||
				op == `FDC_OP_RECAL || op == `FDC_OP_SENSE_INT || op == `FDC_OP_SEEK);
			run_command(op, 8'h00, 8'h00);
		end

		$display("errors: result %0d, status %0d, other %0d",
			result_errors, status_errors, other_errors);
		if (result_errors + status_errors + other_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// budget of 200 cycles per command step
	initial begin
		repeat (STEPS * 200) @(posedge clk_sys);
		$display("watchdog expired: run still going after %0d clock cycles", STEPS * 200);
		$display("Checks failed");
		$finish;
	end

endmodule

//--- fdc.f
+incdir+src
+incdir+tb
src/fdc_pkg.sv
src/fdc_host_port.sv
src/fdc_command_sequencer.sv
src/fdc_result_port.sv
src/fdc_top.sv
tb/tb_fdc.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_fdc
FILELIST  ?= fdc.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
